// ==== source/lpif_pkg.sv ====
////////////////////
// Link-layer side of the LPIF adapter link state machine.
// Request and status encodings plus the port structs toward the link layer.
// Referenced by scoped name from the top level and the FSM.
////////////////////

`default_nettype none

package lpif_pkg;

  // Link-layer state request, reference code values
  typedef enum logic [3:0] {
    REQ_NOP     = 4'h0,
    REQ_ACTIVE  = 4'h1,
    REQ_IDLE_L1 = 4'h4,
    REQ_RETRAIN = 4'hB
  } state_req_e;

  // Physical-layer status reported to the link layer
  typedef enum logic [3:0] {
    STS_RESET      = 4'h0,
    STS_ACTIVE     = 4'h1,
    STS_IDLE_L1    = 4'h4,
    STS_LINK_ERROR = 4'hA,
    STS_RETRAIN    = 4'hB
  } state_sts_e;

  // From the link layer
  typedef struct packed {
    state_req_e state_req;
    logic       exit_cg_ack;
    logic       stallack;
    logic       wake_req;
  } lp_in_t;

  // Toward the link layer
  typedef struct packed {
    state_sts_e state_sts;
    logic       exit_cg_req;
    logic       stallreq;
    logic       wake_ack;
    logic       phyinl1;
    logic       phyinrecenter;
    logic       lnk_up;
    logic       state_active;
  } pl_out_t;

  // Physical layer control inputs
  typedef struct packed {
    logic link_up;
    logic phy_err;
  } ctl_t;

endpackage

`default_nettype wire

// ==== source/sb_pkg.sv ====
////////////////////
// Sideband encodings exchanged with the remote adapter and the
// link state machine state encoding.
// Referenced by scoped name from the top level and the FSM.
////////////////////

`default_nettype none

package sb_pkg;

  // Sideband state codes, same values as on the wire
  typedef enum logic [3:0] {
    SB_NULL        = 4'h0,
    SB_L1_REQ      = 4'h1,
    SB_L1_STS      = 4'h2,
    SB_ACTIVE_REQ  = 4'h3,
    SB_ACTIVE_STS  = 4'h4,
    SB_LINK_ERROR  = 4'h5,
    SB_RETRAIN_STS = 4'hB
  } sb_state_e;

  // Link state machine states
  typedef enum logic [3:0] {
    LSM_RESET        = 4'h0,
    LSM_RESET_A      = 4'h1,
    LSM_RESET_B      = 4'h2,
    LSM_ACTIVE_A     = 4'h3,
    LSM_ACTIVE       = 4'h4,
    LSM_ACTIVE_B     = 4'h5,
    LSM_ACTIVE_C     = 4'h6,
    LSM_IDLE_L1      = 4'h7,
    LSM_LINK_ERROR   = 4'h8,
    LSM_RETRAIN_A    = 4'h9,
    LSM_RETRAIN_WAIT = 4'hA,
    LSM_RETRAIN      = 4'hB,
    LSM_SB_ACK       = 4'hC,
    LSM_SB_ACK_STALL = 4'hD
  } lsm_state_e;

endpackage

`default_nettype wire

// ==== source/lsm_req_track.sv ====
////////////////////
// Link-layer request tracker.
// Flags a new non-NOP request and holds the flag until the FSM
// consumes it.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_req_track (
  input  logic                 lclk,
  input  logic                 rst_n,
  input  lpif_pkg::state_req_e state_req,
  input  logic                 req_consume,
  output logic                 req_changed
);

  lpif_pkg::state_req_e state_req_q;
  logic                 fresh_change;

  // New request this cycle, NOP never counts
  assign fresh_change = (state_req != state_req_q) &&
                        (state_req != lpif_pkg::REQ_NOP);

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_req_q <= lpif_pkg::REQ_NOP;
      req_changed <= 1'b0;
    end
    else
    begin
      state_req_q <= state_req;
      // A fresh change in the consume cycle sets the flag again
      req_changed <= fresh_change || (req_changed && !req_consume);
    end
  end

  // Flag stays low across a NOP request
  a_no_rise_on_nop: assert property (@(posedge lclk) disable iff (!rst_n)
    (!req_changed && state_req == lpif_pkg::REQ_NOP) |=> !req_changed);

endmodule

`default_nettype wire

// ==== source/lsm_req_ack.sv ====
////////////////////
// Held request line for the clock-gating exit and stall handshakes.
// A start pulse raises req; the registered ack releases it.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_req_ack (
  input  logic lclk,
  input  logic rst_n,
  input  logic start,
  input  logic ack,
  output logic req
);

  logic ack_q;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
      req   <= 1'b0;
    end
    else
    begin
      ack_q <= ack;
      // New start wins over release
      if (start)
        req <= 1'b1;
      else if (ack_q)
        req <= 1'b0;
    end
  end

  // Release only after the link layer acknowledged
  a_req_release: assert property (@(posedge lclk) disable iff (!rst_n)
    $fell(req) |-> $past(ack_q));

endmodule

`default_nettype wire

// ==== source/lsm_wake_sync.sv ====
////////////////////
// Wake request synchronizer and acknowledge register.
// wake_ack follows wake_req after SYNC_STAGES+1 clocks.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_wake_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic lclk,
  input  logic rst_n,
  input  logic wake_req,
  output logic wake_ack
);

  logic [SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q   <= '0;
      wake_ack <= 1'b0;
    end
    else
    begin
      sync_q[0] <= wake_req;
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      wake_ack <= sync_q[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

// ==== source/lsm_fsm.sv ====
////////////////////
// LPIF link state machine.
// Walks reset, active, L1, retrain and the link-error trap. Drives the
// status toward the link layer and the downstream sideband code, and
// starts the clock-gating exit and stall handshakes.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_fsm #(
  parameter int RETRAIN_DELAY = 2
) (
  input  logic                 lclk,
  input  logic                 rst_n,
  input  lpif_pkg::state_req_e state_req,
  input  logic                 req_changed,
  input  sb_pkg::sb_state_e    ustrm_state,
  input  lpif_pkg::ctl_t       ctl,
  input  logic                 cg_req,
  input  logic                 cg_ack,
  input  logic                 stall_req,
  input  logic                 stall_ack,
  output logic                 req_consume,
  output logic                 cg_start,
  output logic                 stall_start,
  output lpif_pkg::state_sts_e state_sts,
  output sb_pkg::sb_state_e    dstrm_state,
  output logic                 phyinl1,
  output logic                 phyinrecenter,
  output logic                 lnk_up,
  output logic                 state_active
);

  localparam int CNT_W = (RETRAIN_DELAY > 1) ? $clog2(RETRAIN_DELAY) : 1;

  sb_pkg::lsm_state_e   state, d_state;
  sb_pkg::lsm_state_e   return_state, d_return_state;
  lpif_pkg::state_sts_e d_state_sts;
  sb_pkg::sb_state_e    d_dstrm_state;
  logic                 d_lnk_up;
  logic                 coldstart, d_coldstart;
  logic                 exit_lp, d_exit_lp;
  logic [CNT_W-1:0]     wait_cnt;
  logic                 wait_done;
  logic                 req_active, req_idle_l1, req_retrain;
  logic                 us_l1_req, us_l1_sts, us_active_req;
  logic                 us_active_sts, us_link_error, us_retrain_sts;
  logic                 sb_ack, exit_active;

  ////////////////////
  // Decodes
  ////////////////////
  assign req_active     = (state_req == lpif_pkg::REQ_ACTIVE);
  assign req_idle_l1    = (state_req == lpif_pkg::REQ_IDLE_L1);
  assign req_retrain    = (state_req == lpif_pkg::REQ_RETRAIN);
  assign us_l1_req      = (ustrm_state == sb_pkg::SB_L1_REQ);
  assign us_l1_sts      = (ustrm_state == sb_pkg::SB_L1_STS);
  assign us_active_req  = (ustrm_state == sb_pkg::SB_ACTIVE_REQ);
  assign us_active_sts  = (ustrm_state == sb_pkg::SB_ACTIVE_STS);
  assign us_link_error  = (ustrm_state == sb_pkg::SB_LINK_ERROR);
  assign us_retrain_sts = (ustrm_state == sb_pkg::SB_RETRAIN_STS);

  // Remote side answers while our request is still on the wire
  assign sb_ack = (us_l1_sts && dstrm_state == sb_pkg::SB_L1_REQ) ||
                  (us_active_sts && dstrm_state == sb_pkg::SB_ACTIVE_REQ);

  assign exit_active = coldstart || us_l1_req || us_link_error ||
                       (req_changed && (req_retrain || req_idle_l1));

  assign wait_done    = (wait_cnt == CNT_W'(RETRAIN_DELAY - 1));
  assign state_active = (state_sts == lpif_pkg::STS_ACTIVE);

  ////////////////////
  // Next state
  ////////////////////
  always_comb
  begin
    d_state        = state;
    d_state_sts    = state_sts;
    d_dstrm_state  = dstrm_state;
    d_return_state = return_state;
    d_lnk_up       = lnk_up;
    d_coldstart    = coldstart;
    d_exit_lp      = exit_lp;
    req_consume    = 1'b0;
    cg_start       = 1'b0;
    stall_start    = 1'b0;
    if (ctl.phy_err)
    begin
      d_state       = sb_pkg::LSM_LINK_ERROR;
      d_state_sts   = lpif_pkg::STS_LINK_ERROR;
      d_dstrm_state = sb_pkg::SB_LINK_ERROR;
    end
    else
    begin
      case (state)
        sb_pkg::LSM_RESET:
        begin
          d_state_sts = lpif_pkg::STS_RESET;
          if (ctl.link_up)
            d_state = us_active_req ? sb_pkg::LSM_RESET_B : sb_pkg::LSM_RESET_A;
        end
        sb_pkg::LSM_RESET_B:
        begin
          if (!us_active_req)
            d_state = sb_pkg::LSM_RESET_A;
          else
          begin
            d_dstrm_state = sb_pkg::SB_ACTIVE_STS;
            cg_start      = 1'b1;
            d_state       = sb_pkg::LSM_ACTIVE_A;
          end
        end
        sb_pkg::LSM_RESET_A:
        begin
          d_lnk_up      = 1'b1;
          d_dstrm_state = sb_pkg::SB_NULL;
          if (coldstart || us_active_req)
          begin
            cg_start = 1'b1;
            d_state  = sb_pkg::LSM_ACTIVE_A;
          end
          else if (req_active && req_changed)
            d_state = sb_pkg::LSM_ACTIVE_C;
          else if (us_link_error)
            d_state = sb_pkg::LSM_LINK_ERROR;
        end
        sb_pkg::LSM_ACTIVE_C:
        begin
          d_dstrm_state  = sb_pkg::SB_ACTIVE_REQ;
          d_return_state = sb_pkg::LSM_ACTIVE_A;
          d_state        = sb_pkg::LSM_SB_ACK;
        end
        sb_pkg::LSM_ACTIVE_A:
        begin
          if (cg_req && cg_ack)
          begin
            d_state_sts   = lpif_pkg::STS_ACTIVE;
            d_dstrm_state = sb_pkg::SB_ACTIVE_STS;
            d_state       = sb_pkg::LSM_ACTIVE;
          end
        end
        sb_pkg::LSM_ACTIVE:
        begin
          if (exit_active)
          begin
            req_consume = 1'b1;
            // Local L1 goes to the sideband first, no stall
            stall_start = !req_idle_l1;
            d_state     = sb_pkg::LSM_ACTIVE_B;
          end
        end
        sb_pkg::LSM_ACTIVE_B:
        begin
          if ((stall_req && stall_ack) || req_idle_l1)
          begin
            if (req_retrain || coldstart)
            begin
              d_state_sts   = lpif_pkg::STS_RETRAIN;
              d_dstrm_state = sb_pkg::SB_RETRAIN_STS;
              d_state       = sb_pkg::LSM_RETRAIN_A;
            end
            else if (req_idle_l1)
            begin
              d_dstrm_state  = sb_pkg::SB_L1_REQ;
              d_return_state = sb_pkg::LSM_IDLE_L1;
              d_state        = sb_pkg::LSM_SB_ACK;
            end
            else if (us_l1_req)
            begin
              d_state_sts = lpif_pkg::STS_IDLE_L1;
              d_state     = sb_pkg::LSM_IDLE_L1;
            end
            else if (us_link_error)
              d_state = sb_pkg::LSM_LINK_ERROR;
          end
        end
        sb_pkg::LSM_IDLE_L1:
        begin
          d_state_sts   = lpif_pkg::STS_IDLE_L1;
          d_dstrm_state = sb_pkg::SB_L1_STS;
          if (us_active_req)
            d_state = sb_pkg::LSM_RETRAIN_A;
          else if ((req_active || req_retrain) && req_changed)
          begin
            req_consume    = 1'b1;
            d_exit_lp      = 1'b1;
            d_dstrm_state  = sb_pkg::SB_ACTIVE_REQ;
            d_return_state = sb_pkg::LSM_RETRAIN_A;
            d_state        = sb_pkg::LSM_SB_ACK;
          end
          else if (us_link_error)
            d_state = sb_pkg::LSM_LINK_ERROR;
        end
        sb_pkg::LSM_LINK_ERROR:
        begin
          // Trap until reset
          d_state_sts   = lpif_pkg::STS_LINK_ERROR;
          d_dstrm_state = sb_pkg::SB_LINK_ERROR;
        end
        sb_pkg::LSM_RETRAIN_A:
        begin
          if (!us_active_req)
            d_dstrm_state = sb_pkg::SB_RETRAIN_STS;
          d_state = sb_pkg::LSM_RETRAIN_WAIT;
        end
        sb_pkg::LSM_RETRAIN_WAIT:
        begin
          // Old clock-gating ack must be gone before a new request
          if (wait_done && !cg_ack &&
              (us_active_req || coldstart || exit_lp || us_retrain_sts))
          begin
            d_state_sts = lpif_pkg::STS_RETRAIN;
            d_state     = sb_pkg::LSM_RETRAIN;
          end
        end
        sb_pkg::LSM_RETRAIN:
        begin
          cg_start      = 1'b1;
          d_dstrm_state = sb_pkg::SB_RETRAIN_STS;
          if ((req_active && req_changed) || coldstart || exit_lp)
          begin
            req_consume = 1'b1;
            d_coldstart = 1'b0;
            d_exit_lp   = 1'b0;
            d_state     = sb_pkg::LSM_ACTIVE_A;
          end
          else if (us_active_req)
          begin
            d_dstrm_state = sb_pkg::SB_ACTIVE_STS;
            d_state       = sb_pkg::LSM_ACTIVE_A;
          end
          else if (us_link_error)
            d_state = sb_pkg::LSM_LINK_ERROR;
        end
        sb_pkg::LSM_SB_ACK:
        begin
          if (sb_ack && exit_active)
          begin
            stall_start = 1'b1;
            d_state     = sb_pkg::LSM_SB_ACK_STALL;
          end
          else if (sb_ack)
          begin
            cg_start = (return_state == sb_pkg::LSM_ACTIVE_A);
            d_state  = return_state;
          end
        end
        sb_pkg::LSM_SB_ACK_STALL:
        begin
          if (stall_req && stall_ack)
          begin
            d_state = return_state;
            if (return_state == sb_pkg::LSM_IDLE_L1)
              d_state_sts = lpif_pkg::STS_IDLE_L1;
          end
        end
        default: d_state = sb_pkg::LSM_RESET;
      endcase
    end
  end

  ////////////////////
  // State and status registers
  ////////////////////
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= sb_pkg::LSM_RESET;
      return_state  <= sb_pkg::LSM_RESET;
      state_sts     <= lpif_pkg::STS_RESET;
      dstrm_state   <= sb_pkg::SB_NULL;
      lnk_up        <= 1'b0;
      coldstart     <= 1'b1;
      exit_lp       <= 1'b0;
      phyinl1       <= 1'b0;
      phyinrecenter <= 1'b0;
      wait_cnt      <= '0;
    end
    else
    begin
      state         <= d_state;
      return_state  <= d_return_state;
      state_sts     <= d_state_sts;
      dstrm_state   <= d_dstrm_state;
      lnk_up        <= d_lnk_up;
      coldstart     <= d_coldstart;
      exit_lp       <= d_exit_lp;
      // Flags follow the next status so they move with state_sts
      phyinl1       <= (d_state_sts == lpif_pkg::STS_IDLE_L1);
      phyinrecenter <= (d_state_sts == lpif_pkg::STS_RETRAIN);
      if (state != sb_pkg::LSM_RETRAIN_WAIT)
        wait_cnt <= '0;
      else if (!wait_done)
        wait_cnt <= wait_cnt + 1'b1;
    end
  end

  a_active_sts: assert property (@(posedge lclk) disable iff (!rst_n)
    state == sb_pkg::LSM_ACTIVE |-> state_sts == lpif_pkg::STS_ACTIVE);

  a_phy_err_trap: assert property (@(posedge lclk) disable iff (!rst_n)
    ctl.phy_err |=> state == sb_pkg::LSM_LINK_ERROR &&
                    state_sts == lpif_pkg::STS_LINK_ERROR);

endmodule

`default_nettype wire

// ==== source/lsm_top.sv ====
////////////////////
// Top level of the LPIF link state machine.
// Connects request tracker, FSM, the two handshake blocks and the
// wake synchronizer, and packs the link-layer outputs.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_top #(
  parameter int SYNC_STAGES   = 2,
  parameter int RETRAIN_DELAY = 2
) (
  input  logic               lclk,
  input  logic               rst_n,
  input  lpif_pkg::lp_in_t   lp,
  input  sb_pkg::sb_state_e  ustrm_state,
  input  lpif_pkg::ctl_t     ctl,
  output lpif_pkg::pl_out_t  pl,
  output sb_pkg::sb_state_e  dstrm_state
);

  logic                 req_changed;
  logic                 req_consume;
  logic                 cg_start, cg_req;
  logic                 stall_start, stall_req;
  lpif_pkg::state_sts_e state_sts;
  logic                 phyinl1, phyinrecenter;
  logic                 lnk_up, state_active;
  logic                 wake_ack;

  lsm_req_track req_track_inst (
    .lclk        (lclk),
    .rst_n       (rst_n),
    .state_req   (lp.state_req),
    .req_consume (req_consume),
    .req_changed (req_changed)
  );

  lsm_fsm #(
    .RETRAIN_DELAY (RETRAIN_DELAY)
  ) fsm_inst (
    .lclk          (lclk),
    .rst_n         (rst_n),
    .state_req     (lp.state_req),
    .req_changed   (req_changed),
    .ustrm_state   (ustrm_state),
    .ctl           (ctl),
    .cg_req        (cg_req),
    .cg_ack        (lp.exit_cg_ack),
    .stall_req     (stall_req),
    .stall_ack     (lp.stallack),
    .req_consume   (req_consume),
    .cg_start      (cg_start),
    .stall_start   (stall_start),
    .state_sts     (state_sts),
    .dstrm_state   (dstrm_state),
    .phyinl1       (phyinl1),
    .phyinrecenter (phyinrecenter),
    .lnk_up        (lnk_up),
    .state_active  (state_active)
  );

  // Clock-gating exit handshake
  lsm_req_ack cg_ack_inst (
    .lclk  (lclk),
    .rst_n (rst_n),
    .start (cg_start),
    .ack   (lp.exit_cg_ack),
    .req   (cg_req)
  );

  // Stall handshake
  lsm_req_ack stall_ack_inst (
    .lclk  (lclk),
    .rst_n (rst_n),
    .start (stall_start),
    .ack   (lp.stallack),
    .req   (stall_req)
  );

  lsm_wake_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) wake_sync_inst (
    .lclk     (lclk),
    .rst_n    (rst_n),
    .wake_req (lp.wake_req),
    .wake_ack (wake_ack)
  );

  assign pl = '{
    state_sts:     state_sts,
    exit_cg_req:   cg_req,
    stallreq:      stall_req,
    wake_ack:      wake_ack,
    phyinl1:       phyinl1,
    phyinrecenter: phyinrecenter,
    lnk_up:        lnk_up,
    state_active:  state_active
  };

endmodule

`default_nettype wire

// ==== sim/lsm_checker.sv ====
////////////////////
// Testbench checker for the LPIF link state machine.
// Watches the DUT ports every clock, compares them with the expected
// values and counts checks and errors for the closing line.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module lsm_checker #(
  parameter int SYNC_STAGES = 2,
  parameter int HOLD_LIMIT  = 64
) (
  input  logic                 lclk,
  input  logic                 rst_n,
  input  lpif_pkg::lp_in_t     lp,
  input  lpif_pkg::ctl_t       ctl,
  input  lpif_pkg::pl_out_t    pl,
  input  sb_pkg::sb_state_e    dstrm_state,
  input  logic                 row_start,
  input  logic                 check_en,
  input  logic                 settle_ok,
  input  lpif_pkg::state_sts_e exp_sts,
  input  sb_pkg::sb_state_e    exp_dstrm,
  input  logic                 need_recenter,
  input  logic                 need_stall,
  input  logic                 forbid_l1_req,
  output int                   errors,
  output int                   checks
);

  logic [SYNC_STAGES:0] wake_hist;
  logic                 out_of_reset;
  logic                 phy_err_q;
  logic                 trapped;
  logic                 recenter_seen;
  logic                 stall_seen;
  logic [1:0]           hs_req, hs_ack, hs_req_q, hs_acked, hs_told;
  int                   hold_cnt [2];
  string                hs_name;

  // Index 0 is the clock-gating exit, index 1 the stall
  assign hs_req = {pl.stallreq, pl.exit_cg_req};
  assign hs_ack = {lp.stallack, lp.exit_cg_ack};

  task automatic check_value(input string name, input logic [7:0] exp_v,
                             input logic [7:0] got_v);
    checks++;
    if (exp_v !== got_v)
    begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
      errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  always @(posedge lclk)
  begin
    if (!rst_n)
    begin
      wake_hist     = '0;
      out_of_reset  = 1'b0;
      phy_err_q     = 1'b0;
      trapped       = 1'b0;
      recenter_seen = 1'b0;
      stall_seen    = 1'b0;
      hs_req_q      = '0;
      hs_acked      = '0;
      hs_told       = '0;
      hold_cnt[0]   = 0;
      hold_cnt[1]   = 0;
      errors        = 0;
      checks        = 0;
    end
    else
    begin
      // First edge after release still shows the reset values
      if (!out_of_reset)
      begin
        check_value("pl.state_sts", 8'(lpif_pkg::STS_RESET), 8'(pl.state_sts));
        check_value("dstrm_state", 8'(sb_pkg::SB_NULL), 8'(dstrm_state));
        check_value("pl controls", 8'h00, {1'b0, pl.exit_cg_req, pl.stallreq, pl.wake_ack,
                    pl.phyinl1, pl.phyinrecenter, pl.lnk_up, pl.state_active});
        out_of_reset = 1'b1;
      end

      // Wake ack trails the request by SYNC_STAGES+1 clocks
      check_value("pl.wake_ack", 8'(wake_hist[SYNC_STAGES]), 8'(pl.wake_ack));
      wake_hist = {wake_hist[SYNC_STAGES-1:0], lp.wake_req};

      // Status flags move together with state_sts
      check_value("pl.state_active", 8'(pl.state_sts == lpif_pkg::STS_ACTIVE),
                  8'(pl.state_active));
      check_value("pl.phyinl1", 8'(pl.state_sts == lpif_pkg::STS_IDLE_L1), 8'(pl.phyinl1));
      check_value("pl.phyinrecenter", 8'(pl.state_sts == lpif_pkg::STS_RETRAIN),
                  8'(pl.phyinrecenter));

      // Error trap, one cycle after phy_err and then until reset
      if (phy_err_q || trapped)
      begin
        check_value("pl.state_sts", 8'(lpif_pkg::STS_LINK_ERROR), 8'(pl.state_sts));
        check_value("dstrm_state", 8'(sb_pkg::SB_LINK_ERROR), 8'(dstrm_state));
      end
      if (pl.state_sts == lpif_pkg::STS_LINK_ERROR)
        trapped = 1'b1;
      phy_err_q = ctl.phy_err;

      ////////////////////
      // Per-row checks
      ////////////////////
      if (row_start)
      begin
        recenter_seen = 1'b0;
        stall_seen    = 1'b0;
      end
      else
      begin
        if (pl.phyinrecenter)
          recenter_seen = 1'b1;
        if (pl.stallreq)
          stall_seen = 1'b1;
      end
      if (forbid_l1_req && dstrm_state == sb_pkg::SB_L1_REQ)
        report_problem("dstrm_state showed L1_REQ during a remote L1 entry");
      if (check_en)
      begin
        if (!settle_ok)
          report_problem("state_sts did not settle within the row wait limit");
        check_value("pl.state_sts", 8'(exp_sts), 8'(pl.state_sts));
        check_value("dstrm_state", 8'(exp_dstrm), 8'(dstrm_state));
        check_value("pl.lnk_up", 8'h01, 8'(pl.lnk_up));
        if (need_recenter && !recenter_seen)
          report_problem("state_sts never passed through RETRAIN in this row");
        if (need_stall && !stall_seen)
          report_problem("stallreq never rose in this row");
      end

      // Request lines fall only after their ack, and not hang
      for (int i = 0; i < 2; i++)
      begin
        if (i == 0)
          hs_name = "exit_cg_req";
        else
          hs_name = "stallreq";
        if (hs_req_q[i] && !hs_req[i] && !hs_acked[i])
          report_problem($sformatf("%s fell before its ack was seen", hs_name));
        if (!hs_req[i])
        begin
          hs_acked[i] = 1'b0;
          hs_told[i]  = 1'b0;
          hold_cnt[i] = 0;
        end
        else
        begin
          if (hs_ack[i])
            hs_acked[i] = 1'b1;
          hold_cnt[i]++;
          if (hold_cnt[i] >= HOLD_LIMIT && !hs_told[i])
          begin
            report_problem($sformatf("%s handshake never completed", hs_name));
            hs_told[i] = 1'b1;
          end
        end
      end
      hs_req_q = hs_req;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_lsm.sv ====
////////////////////
// Testbench for the LPIF link state machine.
// Plays a table of link-layer and remote-side stimulus rows, answers
// the handshakes and leaves all comparing to the checker.
////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_lsm;

  localparam int SYNC_STAGES   = 2;
  localparam int NUM_ROWS      = 6;
  localparam int ROW_LIMIT     = 64;
  localparam int SETTLE_CYCLES = 8;
  localparam int TIMEOUT       = NUM_ROWS * ROW_LIMIT + 8 + 50;

  localparam lpif_pkg::ctl_t CTL_UP  = '{link_up: 1'b1, phy_err: 1'b0};
  localparam lpif_pkg::ctl_t CTL_ERR = '{link_up: 1'b1, phy_err: 1'b1};

  // One stimulus row with its expected settled outputs
  typedef struct packed {
    lpif_pkg::state_req_e req;
    sb_pkg::sb_state_e    ustrm;
    logic                 answer;
    lpif_pkg::ctl_t       ctl;
    logic                 wake;
    lpif_pkg::state_sts_e exp_sts;
    sb_pkg::sb_state_e    exp_dstrm;
    logic                 need_recenter;
    logic                 forbid_l1_req;
    logic                 need_stall;
  } row_t;

  logic                 lclk = 1'b0;
  logic                 rst_n;
  lpif_pkg::state_req_e req_d;
  lpif_pkg::ctl_t       ctl_d;
  logic                 wake_d;
  logic                 cg_ack_d = 1'b0;
  logic                 stall_ack_d = 1'b0;
  sb_pkg::sb_state_e    ustrm_state = sb_pkg::SB_NULL;
  sb_pkg::sb_state_e    ustrm_base;
  logic                 answer;
  lpif_pkg::lp_in_t     lp;
  lpif_pkg::pl_out_t    pl;
  sb_pkg::sb_state_e    dstrm_state;
  logic                 row_start, check_en, settle_ok;
  logic                 need_recenter, need_stall, forbid_l1_req;
  lpif_pkg::state_sts_e exp_sts;
  sb_pkg::sb_state_e    exp_dstrm;
  int                   errors, checks;
  int                   cycles = 0;
  integer               seed = 32'hb412;
  row_t                 rows [NUM_ROWS];

  assign lp = '{state_req: req_d, exit_cg_ack: cg_ack_d, stallack: stall_ack_d,
                wake_req: wake_d};

  always #5 lclk = ~lclk;

  lsm_top #(
    .SYNC_STAGES   (SYNC_STAGES),
    .RETRAIN_DELAY (2)
  ) lsm_top_inst (
    .lclk        (lclk),
    .rst_n       (rst_n),
    .lp          (lp),
    .ustrm_state (ustrm_state),
    .ctl         (ctl_d),
    .pl          (pl),
    .dstrm_state (dstrm_state)
  );

  lsm_checker #(
    .SYNC_STAGES (SYNC_STAGES),
    .HOLD_LIMIT  (ROW_LIMIT)
  ) checker_inst (
    .lclk          (lclk),
    .rst_n         (rst_n),
    .lp            (lp),
    .ctl           (ctl_d),
    .pl            (pl),
    .dstrm_state   (dstrm_state),
    .row_start     (row_start),
    .check_en      (check_en),
    .settle_ok     (settle_ok),
    .exp_sts       (exp_sts),
    .exp_dstrm     (exp_dstrm),
    .need_recenter (need_recenter),
    .need_stall    (need_stall),
    .forbid_l1_req (forbid_l1_req),
    .errors        (errors),
    .checks        (checks)
  );

  // Link layer acks one clock after it sees a request
  always @(posedge lclk)
  begin
    if (!rst_n)
    begin
      cg_ack_d    <= 1'b0;
      stall_ack_d <= 1'b0;
    end
    else
    begin
      cg_ack_d    <= pl.exit_cg_req;
      stall_ack_d <= pl.stallreq;
    end
  end

  // Remote side, answers REQ codes with the matching STS in answer mode
  always @(posedge lclk)
  begin
    if (!rst_n)
      ustrm_state <= sb_pkg::SB_NULL;
    else if (answer && dstrm_state == sb_pkg::SB_L1_REQ)
      ustrm_state <= sb_pkg::SB_L1_STS;
    else if (answer && dstrm_state == sb_pkg::SB_ACTIVE_REQ)
      ustrm_state <= sb_pkg::SB_ACTIVE_STS;
    else
      ustrm_state <= ustrm_base;
  end

  always @(posedge lclk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Done: errors found");
      $finish;
    end
  end

  // Status must hold for SETTLE_CYCLES, the bring-up passes through ACTIVE once
  task automatic run_row(input int idx);
    row_t r;
    int   waited;
    int   stable;
    r = rows[idx];
    req_d         <= r.req;
    ustrm_base    <= r.ustrm;
    answer        <= r.answer;
    ctl_d         <= r.ctl;
    wake_d        <= r.wake;
    forbid_l1_req <= r.forbid_l1_req;
    row_start     <= 1'b1;
    @(posedge lclk);
    row_start <= 1'b0;
    waited = 0;
    stable = 0;
    while (stable < SETTLE_CYCLES && waited < ROW_LIMIT)
    begin
      @(posedge lclk);
      waited++;
      if (pl.state_sts == r.exp_sts)
        stable++;
      else
        stable = 0;
      if (($random(seed) & 3) == 0)
        wake_d <= !wake_d;
    end
    exp_sts       <= r.exp_sts;
    exp_dstrm     <= r.exp_dstrm;
    need_recenter <= r.need_recenter;
    need_stall    <= r.need_stall;
    settle_ok     <= (stable >= SETTLE_CYCLES);
    check_en      <= 1'b1;
    @(posedge lclk);
    check_en <= 1'b0;
  endtask

  initial
  begin
    rst_n         = 1'b0;
    req_d         = lpif_pkg::REQ_NOP;
    ctl_d         = '0;
    wake_d        = 1'b0;
    ustrm_base    = sb_pkg::SB_NULL;
    answer        = 1'b0;
    row_start     = 1'b0;
    check_en      = 1'b0;
    settle_ok     = 1'b0;
    need_recenter = 1'b0;
    need_stall    = 1'b0;
    forbid_l1_req = 1'b0;
    exp_sts       = lpif_pkg::STS_RESET;
    exp_dstrm     = sb_pkg::SB_NULL;
    // req, ustrm, answer, ctl, wake, exp_sts, exp_dstrm, recenter, no L1_REQ, stall
    rows[0] = '{lpif_pkg::REQ_NOP, sb_pkg::SB_NULL, 1'b1, CTL_UP, 1'b0,
                lpif_pkg::STS_ACTIVE, sb_pkg::SB_ACTIVE_STS, 1'b1, 1'b0, 1'b1};
    rows[1] = '{lpif_pkg::REQ_IDLE_L1, sb_pkg::SB_NULL, 1'b1, CTL_UP, 1'b1,
                lpif_pkg::STS_IDLE_L1, sb_pkg::SB_L1_STS, 1'b0, 1'b0, 1'b0};
    rows[2] = '{lpif_pkg::REQ_ACTIVE, sb_pkg::SB_NULL, 1'b1, CTL_UP, 1'b0,
                lpif_pkg::STS_ACTIVE, sb_pkg::SB_ACTIVE_STS, 1'b1, 1'b0, 1'b0};
    rows[3] = '{lpif_pkg::REQ_ACTIVE, sb_pkg::SB_L1_REQ, 1'b0, CTL_UP, 1'b1,
                lpif_pkg::STS_IDLE_L1, sb_pkg::SB_L1_STS, 1'b0, 1'b1, 1'b1};
    rows[4] = '{lpif_pkg::REQ_ACTIVE, sb_pkg::SB_NULL, 1'b0, CTL_ERR, 1'b0,
                lpif_pkg::STS_LINK_ERROR, sb_pkg::SB_LINK_ERROR, 1'b0, 1'b0, 1'b0};
    // phy_err released, the trap holds
    rows[5] = '{lpif_pkg::REQ_ACTIVE, sb_pkg::SB_ACTIVE_REQ, 1'b0, CTL_UP, 1'b1,
                lpif_pkg::STS_LINK_ERROR, sb_pkg::SB_LINK_ERROR, 1'b0, 1'b0, 1'b0};
    repeat (8) @(posedge lclk);
    rst_n <= 1'b1;
    @(posedge lclk);
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    repeat (4) @(posedge lclk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/lpif_pkg.sv
source/sb_pkg.sv
source/lsm_req_track.sv
source/lsm_req_ack.sv
source/lsm_wake_sync.sv
source/lsm_fsm.sv
source/lsm_top.sv
sim/lsm_checker.sv
sim/tb_lsm.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the link state machine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_lsm -f files.f -Mdir obj_dir -o tb_lsm_sim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/tb_lsm_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
  exit 0
fi
exit 1
